// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All checks passed

SOURCES := $(wildcard hw/*.sv hw/*.svh verif/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/rvga_bus_pkg.sv ====
package rvga_bus_pkg;

  // Operation currently driven on the line bus
  typedef enum logic [1:0] {
    bus_idle,
    bus_read,
    bus_write
  } rvga_bus_op_e;

  typedef enum logic [1:0] {
    st_lookup,
    st_writeback, // Dirty victim going out
    st_fill,
    st_reply      // Line present, finish the CPU access
  } rvga_cache_state_e;

endpackage

// ==== hw/rvga_defs.svh ====
`ifndef RVGA_DEFS_SVH
`define RVGA_DEFS_SVH

// CPU word width in bits
`define RVGA_WORD_BITS 32

// Bytes per cache line, 8 words
`define RVGA_LINE_BYTES 32

// Backing memory size in bytes
`define RVGA_MEM_BYTES 4096

// Direct-mapped, one line per set
`define RVGA_CACHE_SETS 16

// Cycles the line memory waits before serving an access
`define RVGA_MEM_LATENCY 4

`endif

// ==== hw/rvga_line_cache.sv ====
`include "rvga_defs.svh"

module rvga_line_cache (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       cpu_read_i,
  input  logic                       cpu_write_i,
  input  rvga_types_pkg::rvga_word_t cpu_addr_i,
  input  rvga_types_pkg::rvga_word_t cpu_wdata_i,
  output rvga_types_pkg::rvga_word_t cpu_rdata_o,
  output logic                       cpu_resp_o,
  rvga_membus_if.master              mem
);

  localparam int SETS   = `RVGA_CACHE_SETS;
  localparam int WB     = `RVGA_WORD_BITS;
  localparam int WSEL_W = $clog2(`RVGA_LINE_BYTES * 8 / `RVGA_WORD_BITS);
  localparam int OFF_W  = $bits(rvga_types_pkg::rvga_offset_t);

  rvga_types_pkg::rvga_line_t data_q [SETS];
  rvga_types_pkg::rvga_tag_t  tag_q  [SETS];
  logic [SETS-1:0]            valid_q;
  logic [SETS-1:0]            dirty_q;

  rvga_bus_pkg::rvga_cache_state_e state_q;
  rvga_bus_pkg::rvga_bus_op_e      op_q;

  rvga_types_pkg::rvga_addr_u  addr;
  rvga_types_pkg::rvga_addr_u  victim_addr;
  rvga_types_pkg::rvga_addr_u  fill_addr;
  rvga_types_pkg::rvga_index_t idx;
  logic [WSEL_W-1:0]           word_sel;
  rvga_types_pkg::rvga_word_t  sel_word;
  rvga_types_pkg::rvga_line_t  merged_line;

  logic req;
  logic lookup_req;
  logic hit;
  logic victim_dirty;
  logic access;
  logic wb_start;
  logic fill_start;
  logic fill_done;

  assign addr     = cpu_addr_i;
  assign idx      = addr.f.index;
  assign word_sel = addr.f.offset[OFF_W-1 -: WSEL_W];

  // No new request while the previous response is out
  assign req          = (cpu_read_i || cpu_write_i) && !cpu_resp_o;
  assign lookup_req   = (state_q == rvga_bus_pkg::st_lookup) && req;
  assign hit          = valid_q[idx] && (tag_q[idx] == addr.f.tag);
  assign victim_dirty = valid_q[idx] && dirty_q[idx];

  assign access     = (lookup_req && hit) || (state_q == rvga_bus_pkg::st_reply);
  assign wb_start   = lookup_req && !hit && victim_dirty;
  assign fill_start = (lookup_req && !hit && !victim_dirty)
                   || ((state_q == rvga_bus_pkg::st_writeback) && mem.resp);
  assign fill_done  = (state_q == rvga_bus_pkg::st_fill) && mem.resp;

  assign sel_word = data_q[idx][word_sel*WB +: WB];

  always_comb begin
    merged_line = data_q[idx];
    merged_line[word_sel*WB +: WB] = cpu_wdata_i;
  end

  always_comb begin
    victim_addr.f.tag    = tag_q[idx];
    victim_addr.f.index  = idx;
    victim_addr.f.offset = '0;
    fill_addr.f.tag      = addr.f.tag;
    fill_addr.f.index    = idx;
    fill_addr.f.offset   = '0;
  end

  assign mem.read  = (op_q == rvga_bus_pkg::bus_read);
  assign mem.write = (op_q == rvga_bus_pkg::bus_write);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= rvga_bus_pkg::st_lookup;
      op_q       <= rvga_bus_pkg::bus_idle;
      valid_q    <= '0;
      dirty_q    <= '0;
      cpu_resp_o <= 1'b0;
    end else begin
      cpu_resp_o <= access;
      if (fill_done) begin
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= 1'b0;
      end
      if (access && cpu_write_i) begin
        dirty_q[idx] <= 1'b1;
      end
      case (state_q)
        rvga_bus_pkg::st_lookup: begin
          if (wb_start) begin
            state_q <= rvga_bus_pkg::st_writeback;
            op_q    <= rvga_bus_pkg::bus_write;
          end else if (fill_start) begin
            state_q <= rvga_bus_pkg::st_fill;
            op_q    <= rvga_bus_pkg::bus_read;
          end
        end
        rvga_bus_pkg::st_writeback: begin
          if (mem.resp) begin // Memory ignores strobes for a cycle after resp
            state_q <= rvga_bus_pkg::st_fill;
            op_q    <= rvga_bus_pkg::bus_read;
          end
        end
        rvga_bus_pkg::st_fill: begin
          if (mem.resp) begin
            state_q <= rvga_bus_pkg::st_reply;
            op_q    <= rvga_bus_pkg::bus_idle;
          end
        end
        rvga_bus_pkg::st_reply: state_q <= rvga_bus_pkg::st_lookup;
        default:                state_q <= rvga_bus_pkg::st_lookup;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      cpu_rdata_o <= sel_word;
      if (cpu_write_i) begin
        data_q[idx] <= merged_line;
      end
    end
    if (fill_done) begin
      data_q[idx] <= mem.rdata;
      tag_q[idx]  <= addr.f.tag;
    end
    if (wb_start) begin
      mem.addr  <= victim_addr.raw; // Victim goes back under its old tag
      mem.wdata <= data_q[idx];
    end else if (fill_start) begin
      mem.addr <= fill_addr.raw;
    end
  end

endmodule

// ==== hw/rvga_line_memory.sv ====
`include "rvga_defs.svh"

module rvga_line_memory #(
  parameter int LATENCY = 0
) (
  input logic clk,
  input logic reset_i,
  rvga_membus_if.slave bus
);

  localparam int MEM_AW = $clog2(`RVGA_MEM_BYTES);
  localparam int OFF_W  = $clog2(`RVGA_LINE_BYTES);
  localparam int CNT_W  = (LATENCY > 0) ? $clog2(LATENCY + 1) : 1;

  typedef enum logic [1:0] {
    mem_idle,
    mem_busy,
    mem_respond
  } mem_state_e;

  rvga_types_pkg::rvga_byte_t mem_q [`RVGA_MEM_BYTES];

  mem_state_e                 state_q;
  logic [CNT_W-1:0]           cnt_q;
  rvga_types_pkg::rvga_addr_u req_addr;
  logic [MEM_AW-1:0]          base;
  logic                       access;

  assign req_addr = bus.addr;
  assign base     = {req_addr.raw[MEM_AW-1:OFF_W], {OFF_W{1'b0}}}; // Wraps at memory size
  assign access   = (state_q == mem_busy) && (cnt_q == '0);

  // Identity image, each word holds its own byte address
  initial begin
    for (int i = 0; i < `RVGA_MEM_BYTES; i += 4) begin
      rvga_types_pkg::rvga_word_t w;
      w = rvga_types_pkg::rvga_word_t'(i);
      mem_q[i]     = w[7:0];
      mem_q[i + 1] = w[15:8];
      mem_q[i + 2] = w[23:16];
      mem_q[i + 3] = w[31:24];
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q  <= mem_idle;
      cnt_q    <= '0;
      bus.resp <= 1'b0;
    end else begin
      bus.resp <= 1'b0;
      case (state_q)
        mem_idle: begin
          if (bus.read || bus.write) begin
            state_q <= mem_busy;
            cnt_q   <= CNT_W'(LATENCY);
          end
        end
        mem_busy: begin
          if (access) begin
            state_q  <= mem_respond;
            bus.resp <= 1'b1;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        mem_respond: state_q <= mem_idle; // Strobe still high here, ignore it
        default:     state_q <= mem_idle;
      endcase
    end
  end

  // Little-endian byte lanes across the line
  always_ff @(posedge clk) begin
    if (access) begin
      if (bus.write) begin
        for (int b = 0; b < `RVGA_LINE_BYTES; b++) begin
          mem_q[base + MEM_AW'(b)] <= bus.wdata[b*8 +: 8];
        end
      end else begin
        for (int b = 0; b < `RVGA_LINE_BYTES; b++) begin
          bus.rdata[b*8 +: 8] <= mem_q[base + MEM_AW'(b)];
        end
      end
    end
  end

endmodule

// ==== hw/rvga_membus_if.sv ====
interface rvga_membus_if;

  rvga_types_pkg::rvga_word_t addr;  // Line aligned by the memory
  logic                       read;
  logic                       write;
  rvga_types_pkg::rvga_line_t wdata;
  rvga_types_pkg::rvga_line_t rdata;
  logic                       resp;  // One cycle, rdata valid with it

  modport master (
    output addr,
    output read,
    output write,
    output wdata,
    input  rdata,
    input  resp
  );

  modport slave (
    input  addr,
    input  read,
    input  write,
    input  wdata,
    output rdata,
    output resp
  );

endinterface

// ==== hw/rvga_top.sv ====
`include "rvga_defs.svh"

module rvga_top (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       cpu_read_i,
  input  logic                       cpu_write_i,
  input  rvga_types_pkg::rvga_word_t cpu_addr_i,
  input  rvga_types_pkg::rvga_word_t cpu_wdata_i,
  output rvga_types_pkg::rvga_word_t cpu_rdata_o,
  output logic                       cpu_resp_o
);

  rvga_membus_if membus ();

  rvga_line_cache i_cache (
    .clk         (clk),
    .reset_i     (reset_i),
    .cpu_read_i  (cpu_read_i),
    .cpu_write_i (cpu_write_i),
    .cpu_addr_i  (cpu_addr_i),
    .cpu_wdata_i (cpu_wdata_i),
    .cpu_rdata_o (cpu_rdata_o),
    .cpu_resp_o  (cpu_resp_o),
    .mem         (membus.master)
  );

  rvga_line_memory #(
    .LATENCY (`RVGA_MEM_LATENCY)
  ) i_memory (
    .clk     (clk),
    .reset_i (reset_i),
    .bus     (membus.slave)
  );

endmodule

// ==== hw/rvga_types_pkg.sv ====
`include "rvga_defs.svh"

package rvga_types_pkg;

  typedef logic [`RVGA_WORD_BITS-1:0] rvga_word_t;
  typedef logic [7:0] rvga_byte_t;
  typedef logic [`RVGA_LINE_BYTES*8-1:0] rvga_line_t;

  typedef logic [$clog2(`RVGA_LINE_BYTES)-1:0] rvga_offset_t; // Byte in line
  typedef logic [$clog2(`RVGA_CACHE_SETS)-1:0] rvga_index_t;
  typedef logic [`RVGA_WORD_BITS-$clog2(`RVGA_CACHE_SETS)
                 -$clog2(`RVGA_LINE_BYTES)-1:0] rvga_tag_t;

  typedef struct packed {
    rvga_tag_t    tag;
    rvga_index_t  index;
    rvga_offset_t offset; // Upper bits select the word
  } rvga_addr_fields_t;

  // Same address word seen raw or split for the cache lookup
  typedef union packed {
    rvga_word_t        raw;
    rvga_addr_fields_t f;
  } rvga_addr_u;

endpackage

// ==== list.f ====
+incdir+hw
hw/rvga_types_pkg.sv
hw/rvga_bus_pkg.sv
hw/rvga_membus_if.sv
hw/rvga_line_memory.sv
hw/rvga_line_cache.sv
hw/rvga_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== verif/tb_checker.sv ====
module tb_checker (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       read_i,
  input  logic                       write_i,
  input  rvga_types_pkg::rvga_word_t addr_i,
  input  rvga_types_pkg::rvga_word_t wdata_i,
  input  rvga_types_pkg::rvga_word_t rdata_i,
  input  logic                       resp_i,
  input  logic                       expect_hit_i,
  output int                         pass_count_o,
  output int                         fail_count_o,
  output int                         done_count_o
);

  timeunit 1ns;
  timeprecision 100ps;

  rvga_types_pkg::rvga_word_t shadow [1024]; // Word view of the 4 KiB memory

  int pass_count = 0;
  int fail_count = 0;
  int done_count = 0;

  logic                        active = 1'b0;
  bit                          reset_seen = 1'b0; // Response register loaded by reset
  int unsigned                 cycles;
  rvga_bus_pkg::rvga_bus_op_e  op;
  rvga_types_pkg::rvga_word_t  req_addr;
  rvga_types_pkg::rvga_word_t  req_wdata;
  logic                        want_hit;

  assign pass_count_o = pass_count;
  assign fail_count_o = fail_count;
  assign done_count_o = done_count;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = i * 4; // Identity image
    end
  end

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    fail_count++;
  endtask

  // Score the finished request on its response
  task automatic close_request();
    logic ok;
    ok = 1'b1;
    if (op == rvga_bus_pkg::bus_write) begin
      shadow[req_addr[11:2]] = req_wdata;
    end else if (rdata_i !== shadow[req_addr[11:2]]) begin
      report_error($sformatf("read %h expected %h got %h",
                             req_addr, shadow[req_addr[11:2]], rdata_i));
      ok = 1'b0;
    end
    if (want_hit && cycles != 1) begin
      report_error($sformatf("hit at %h answered after %0d cycles, expected 1",
                             req_addr, cycles));
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
    end
    $display("test %0d: %s addr %h latency %0d %s", done_count, op.name(), req_addr,
             cycles, ok ? "ok" : "FAIL");
  endtask

  always @(posedge clk) begin
    if (reset_i) begin
      if (reset_seen && resp_i !== 1'b0) begin
        report_error("cpu_resp_o not low during reset");
      end
      reset_seen = 1'b1;
      active     = 1'b0;
    end else if (active) begin
      cycles++;
      if (resp_i) begin
        active = 1'b0;
        done_count++;
        close_request();
      end
    end else begin
      if (resp_i !== 1'b0) begin
        report_error("cpu_resp_o high with no request pending"); // Also a second pulse
      end
      if (read_i || write_i) begin
        active    = 1'b1;
        cycles    = 0;
        op        = write_i ? rvga_bus_pkg::bus_write : rvga_bus_pkg::bus_read;
        req_addr  = addr_i;
        req_wdata = wdata_i;
        want_hit  = expect_hit_i;
      end
    end
  end

endmodule

// ==== verif/tb_top.sv ====
`include "rvga_defs.svh"

module tb_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;

  typedef struct {
    rvga_bus_pkg::rvga_bus_op_e op;
    rvga_types_pkg::rvga_word_t addr;
    rvga_types_pkg::rvga_word_t wdata;
    bit                         rand_data;
    bit                         expect_hit;
    int unsigned                gap;        // Idle cycles after the response
  } step_t;

  logic                       clk;
  logic                       reset_i;
  logic                       cpu_read_i;
  logic                       cpu_write_i;
  rvga_types_pkg::rvga_word_t cpu_addr_i;
  rvga_types_pkg::rvga_word_t cpu_wdata_i;
  rvga_types_pkg::rvga_word_t cpu_rdata_o;
  logic                       cpu_resp_o;
  logic                       expect_hit;

  int pass_count;
  int fail_count;
  int done_count;

  step_t stim_q [$];
  bit    table_ready = 1'b0;

  rvga_top i_dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .cpu_read_i  (cpu_read_i),
    .cpu_write_i (cpu_write_i),
    .cpu_addr_i  (cpu_addr_i),
    .cpu_wdata_i (cpu_wdata_i),
    .cpu_rdata_o (cpu_rdata_o),
    .cpu_resp_o  (cpu_resp_o)
  );

  tb_checker i_checker (
    .clk          (clk),
    .reset_i      (reset_i),
    .read_i       (cpu_read_i),
    .write_i      (cpu_write_i),
    .addr_i       (cpu_addr_i),
    .wdata_i      (cpu_wdata_i),
    .rdata_i      (cpu_rdata_o),
    .resp_i       (cpu_resp_o),
    .expect_hit_i (expect_hit),
    .pass_count_o (pass_count),
    .fail_count_o (fail_count),
    .done_count_o (done_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic add_step(input rvga_bus_pkg::rvga_bus_op_e op,
                          input rvga_types_pkg::rvga_word_t addr,
                          input rvga_types_pkg::rvga_word_t wdata,
                          input bit rand_data, input bit expect_hit, input int unsigned gap);
    step_t s;
    s.op         = op;
    s.addr       = addr;
    s.wdata      = wdata;
    s.rand_data  = rand_data;
    s.expect_hit = expect_hit;
    s.gap        = gap;
    stim_q.push_back(s);
  endtask

  task automatic build_table();
    rvga_types_pkg::rvga_word_t a;
    add_step(rvga_bus_pkg::bus_read, 'h000, 0, 0, 0, 0); // Cold lines, several sets
    add_step(rvga_bus_pkg::bus_read, 'h024, 0, 0, 0, 0);
    add_step(rvga_bus_pkg::bus_read, 'h0a8, 0, 0, 0, 0);
    add_step(rvga_bus_pkg::bus_read, 'h1fc, 0, 0, 0, 2);
    add_step(rvga_bus_pkg::bus_read, 'h004, 0, 0, 1, 0); // Resident now
    add_step(rvga_bus_pkg::bus_read, 'h0ac, 0, 0, 1, 2);
    add_step(rvga_bus_pkg::bus_write, 'h048, 'hdeadbeef, 0, 0, 0);
    add_step(rvga_bus_pkg::bus_read, 'h048, 0, 0, 1, 0);
    add_step(rvga_bus_pkg::bus_read, 'h044, 0, 0, 1, 0); // Neighbours untouched
    add_step(rvga_bus_pkg::bus_read, 'h04c, 0, 0, 1, 3);
    // Three tags on set 6 push the dirty line out and back
    add_step(rvga_bus_pkg::bus_write, 'h0c8, 'ha5a51234, 0, 0, 0);
    add_step(rvga_bus_pkg::bus_read, 'h2c4, 0, 0, 0, 0);
    add_step(rvga_bus_pkg::bus_read, 'h4cc, 0, 0, 0, 0);
    add_step(rvga_bus_pkg::bus_read, 'h0c8, 0, 0, 0, 0);
    add_step(rvga_bus_pkg::bus_read, 'h0cc, 0, 0, 1, 2);
    for (int i = 0; i < 12; i++) begin
      a = (i * 'h2b4 + 'h104) & 'hffc;
      add_step(rvga_bus_pkg::bus_write, a, 0, 1, 0, 0);
    end
    for (int i = 0; i < 12; i++) begin
      a = (i * 'h2b4 + 'h104) & 'hffc;
      add_step(rvga_bus_pkg::bus_read, a, 0, 0, 0, 0);
    end
  endtask

  // Hold the request until the response pulse
  task automatic run_step(input step_t s);
    @(negedge clk);
    cpu_addr_i  = s.addr;
    cpu_wdata_i = s.rand_data ? $urandom() : s.wdata;
    cpu_read_i  = (s.op == rvga_bus_pkg::bus_read);
    cpu_write_i = (s.op == rvga_bus_pkg::bus_write);
    expect_hit  = s.expect_hit;
    do @(negedge clk); while (!cpu_resp_o);
    cpu_read_i  = 1'b0;
    cpu_write_i = 1'b0;
    expect_hit  = 1'b0;
    repeat (s.gap) @(negedge clk);
  endtask

  initial begin
    int fails;
    void'($urandom(32'h14793ed5));
    reset_i     = 1'b1;
    cpu_read_i  = 1'b0;
    cpu_write_i = 1'b0;
    cpu_addr_i  = '0;
    cpu_wdata_i = '0;
    expect_hit  = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset_i = 1'b0;
    foreach (stim_q[i]) begin
      run_step(stim_q[i]);
    end
    repeat (4) @(negedge clk); // Catch late extra pulses
    fails = fail_count;
    if (done_count != stim_q.size()) begin
      $display("Only %0d of %0d requests got a response", done_count, stim_q.size());
      fails++;
    end
    $display("Passed %0d, failed %0d", pass_count, fails);
    if (fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Budget per request covers a writeback plus a fill
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = stim_q.size() * (2 * (`RVGA_MEM_LATENCY + 2) + 4) * CLK_PERIOD
             + RESET_CYCLES * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Checks failed");
    $finish;
  end

endmodule
